//--- common/serdes_consts.svh
// ========================================
// K and D code values, FIFO size, CRC seed
// ========================================
`ifndef SERDES_CONSTS_SVH
`define SERDES_CONSTS_SVH

// Valid K codes seen on the link
`define K_COMMA     8'hBC   // K28.5
`define K_IDLE      8'h3C   // K28.1
`define K_PKT_START 8'hDC   // K28.6
`define K_PKT_END   8'h9C   // K28.4
`define K_XON       8'h5C   // K28.2
`define K_XOFF      8'h7C   // K28.3

// Invalid K codes, used by the link monitor
`define K_LOS       8'hFF   // K31.7, loss of signal
`define K_ERROR     8'h00   // K0.0, decode error

// Data byte paired with the comma as fill
`define D_56        8'hC5   // D5.6

// Receive FIFO address width, 2^AW - 1 usable entries
`define RX_FIFO_AW  9

// CRC-16 start value
`define CRC_INIT    16'hFFFF

`endif

//--- common/serdes_sym_pkg.sv
// ========================================
// Types of the decoded symbol stream
// ========================================
package serdes_sym_pkg;

   // One decoded byte
   typedef logic [7:0] sym_byte_t;

   // Two bytes, low byte first on the line
   typedef logic [15:0] half_word_t;

   // Symbol pair as delivered by the deserializer each cycle
   typedef struct packed {
      logic       k_msb;   // High byte is a K code
      logic       k_lsb;   // Low byte is a K code
      half_word_t data;
   } sym_pair_t;

endpackage

//--- common/serdes_pkt_pkg.sv
// ========================================
// Packet line, FIFO entry and framer types
// ========================================
package serdes_pkt_pkg;

   // Assembled line, first half-word in the low half
   typedef logic [31:0] line_t;

   // Counts reported to the consumer side
   typedef logic [15:0] fifo_level_t;

   // Consumer flags, bit 0 start, bit 1 end
   typedef logic [3:0] rx_flags_t;

   typedef struct packed {
      logic  error;
      logic  sop;
      logic  eop;
      line_t line;
   } rx_entry_t;

   // Packet framer states
   typedef enum logic [2:0] {
      IDLE,
      FIRSTLINE1,
      FIRSTLINE2,
      PKT1,
      PKT2,
      CRC_CHECK,
      ERROR,
      DONE
   } framer_state_t;

endpackage

//--- source/serdes_crc16.sv
// ========================================
// CRC-16 register, one half-word per step
// ========================================
`include "serdes_consts.svh"

module serdes_crc16 (
   input  logic                       ser_rx_clk,
   input  logic                       rst_rxclk,
   input  logic                       clear_i,
   input  logic                       step_i,
   input  serdes_sym_pkg::half_word_t data_i,
   output serdes_sym_pkg::half_word_t crc_o
);
   import serdes_sym_pkg::*;

   localparam half_word_t poly = 16'h1021;   // CCITT, x^16 + x^12 + x^5 + 1

   // Bit-serial form unrolled over 16 bits, bit 15 first
   function automatic half_word_t crc_next(input half_word_t crc, input half_word_t data);
      half_word_t c;
      logic       fb;
      c = crc;
      for (int i = 15; i >= 0; i--)
      begin
         fb = c[15] ^ data[i];
         c  = {c[14:0], 1'b0};
         if (fb)
            c = c ^ poly;
      end
      return c;
   endfunction

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk || clear_i)
         crc_o <= `CRC_INIT;
      else if (step_i)
         crc_o <= crc_next(crc_o, data_i);
   end

endmodule

//--- serdes_rx/serdes_rx_align.sv
// ========================================
// Byte alignment, XON/XOFF detect, link monitor
// ========================================
`include "serdes_consts.svh"

module serdes_rx_align (
   input  logic                      ser_rx_clk,
   input  logic                      rst_rxclk,
   input  serdes_sym_pkg::sym_pair_t rx_sym_i,
   output serdes_sym_pkg::sym_pair_t even_sym_o,
   output serdes_sym_pkg::sym_pair_t odd_sym_o,
   output logic                      xon_rcvd_o,
   output logic                      xoff_rcvd_o,
   output logic                      link_up_o
);
   import serdes_sym_pkg::*;

   sym_byte_t  lo_byte;
   sym_byte_t  hi_byte;
   logic       hold_k;      // K flag of the previous high byte
   sym_byte_t  hold_byte;   // Previous high byte
   logic       xon_now;
   logic       xoff_now;
   logic       pair_good;
   logic [3:0] good_hist;

   assign lo_byte = rx_sym_i.data[7:0];
   assign hi_byte = rx_sym_i.data[15:8];

   assign even_sym_o = rx_sym_i;   // Even alignment is the raw input

   // Either byte may carry the flow-control code
   assign xon_now  = (rx_sym_i.k_lsb && (lo_byte == `K_XON)) ||
                     (rx_sym_i.k_msb && (hi_byte == `K_XON));
   assign xoff_now = (rx_sym_i.k_lsb && (lo_byte == `K_XOFF)) ||
                     (rx_sym_i.k_msb && (hi_byte == `K_XOFF));

   // Decode error or loss of signal on both bytes marks a bad pair
   assign pair_good = (rx_sym_i != {2'b11, `K_ERROR, `K_ERROR}) &&
                      (rx_sym_i != {2'b11, `K_LOS, `K_LOS});

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         hold_k      <= 1'b0;
         hold_byte   <= '0;
         odd_sym_o   <= '0;
         xon_rcvd_o  <= 1'b0;
         xoff_rcvd_o <= 1'b0;
         good_hist   <= '0;
         link_up_o   <= 1'b0;
      end
      else
      begin
         hold_k    <= rx_sym_i.k_msb;
         hold_byte <= hi_byte;

         // Earlier high byte goes low, current low byte goes high
         odd_sym_o.k_msb <= rx_sym_i.k_lsb;
         odd_sym_o.k_lsb <= hold_k;
         odd_sym_o.data  <= {lo_byte, hold_byte};

         xon_rcvd_o  <= xon_now;
         xoff_rcvd_o <= xoff_now;

         good_hist <= {good_hist[2:0], pair_good};
         link_up_o <= &good_hist[3:1];   // Three clean stages in a row
      end
   end

endmodule

//--- serdes_rx/serdes_rx_framer.sv
// ========================================
// Packet framer, line assembly and CRC check
// ========================================
`include "serdes_consts.svh"

module serdes_rx_framer (
   input  logic                       ser_rx_clk,
   input  logic                       rst_rxclk,
   input  serdes_sym_pkg::sym_pair_t  even_sym_i,
   input  serdes_sym_pkg::sym_pair_t  odd_sym_i,
   input  logic                       full_i,
   input  serdes_sym_pkg::half_word_t crc_value_i,
   output logic                       crc_clear_o,
   output logic                       crc_step_o,
   output serdes_sym_pkg::half_word_t crc_data_o,
   output logic                       fifo_write_o,
   output serdes_pkt_pkg::rx_entry_t  wr_entry_o
);
   import serdes_sym_pkg::*;
   import serdes_pkt_pkg::*;

   localparam sym_pair_t start_pair = {2'b11, `K_PKT_START, `K_PKT_START};
   localparam sym_pair_t end_pair   = {2'b11, `K_PKT_END, `K_PKT_END};
   localparam sym_pair_t comma_fill = {2'b10, `K_COMMA, `D_56};
   localparam sym_pair_t xon_fill   = {2'b11, `K_XON, `K_XON};
   localparam sym_pair_t xoff_fill  = {2'b11, `K_XOFF, `K_XOFF};

   framer_state_t state;
   logic          odd_sel;    // Packet locked to the odd alignment
   sym_pair_t     chosen;
   logic          is_data;
   logic          is_fill;
   half_word_t    half_q;     // First half of the line being built
   line_t         line_q;     // Completed line waiting for its write
   logic          held_q;
   logic          first_q;    // Held line opens the packet

   assign chosen  = odd_sel ? odd_sym_i : even_sym_i;
   assign is_data = !chosen.k_msb && !chosen.k_lsb;
   assign is_fill = (chosen == comma_fill) || (chosen == xon_fill) || (chosen == xoff_fill);

   // CRC restarts while idle and covers only payload half-words
   assign crc_clear_o = (state == IDLE);
   assign crc_step_o  = is_data && (state inside {FIRSTLINE1, FIRSTLINE2, PKT1, PKT2});
   assign crc_data_o  = chosen.data;

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         state        <= IDLE;
         odd_sel      <= 1'b0;
         held_q       <= 1'b0;
         first_q      <= 1'b0;
         fifo_write_o <= 1'b0;
      end
      else
      begin
         fifo_write_o <= 1'b0;
         case (state)
            IDLE:
            begin
               held_q <= 1'b0;
               if (even_sym_i == start_pair)
               begin
                  odd_sel <= 1'b0;
                  state   <= FIRSTLINE1;
               end
               else if (odd_sym_i == start_pair)
               begin
                  odd_sel <= 1'b1;
                  state   <= FIRSTLINE1;
               end
            end

            FIRSTLINE1, PKT1:
            begin
               if (is_data)
               begin
                  half_q <= chosen.data;
                  state  <= (state == FIRSTLINE1) ? FIRSTLINE2 : PKT2;
               end
               else if ((state == PKT1) && (chosen == end_pair))
                  state <= CRC_CHECK;
               else if (!is_fill)   // Fill just stalls
                  state <= ERROR;
            end

            FIRSTLINE2, PKT2:
            begin
               if (is_data)
               begin
                  if (full_i)
                     state <= ERROR;
                  else
                  begin
                     // Previous line goes out now, the new one waits
                     if (held_q)
                     begin
                        fifo_write_o <= 1'b1;
                        wr_entry_o   <= '{error: 1'b0, sop: first_q, eop: 1'b0, line: line_q};
                     end
                     line_q  <= {chosen.data, half_q};
                     held_q  <= 1'b1;
                     first_q <= (state == FIRSTLINE2);
                     state   <= PKT1;
                  end
               end
               else if (!is_fill)
                  state <= ERROR;
            end

            CRC_CHECK:
            begin
               if (chosen == {2'b00, crc_value_i})
               begin
                  if (full_i)
                     state <= ERROR;
                  else
                  begin
                     fifo_write_o <= 1'b1;   // Last line closes the packet
                     wr_entry_o   <= '{error: 1'b0, sop: first_q, eop: 1'b1, line: line_q};
                     held_q       <= 1'b0;
                     state        <= DONE;
                  end
               end
               else if (!is_fill)
                  state <= ERROR;
            end

            ERROR:
            begin
               // Wait for room, then flag the broken packet
               if (!full_i)
               begin
                  fifo_write_o <= 1'b1;
                  wr_entry_o   <= '{error: 1'b1, sop: 1'b0, eop: 1'b0, line: '0};
                  held_q       <= 1'b0;
                  state        <= IDLE;
               end
            end

            DONE:
               state <= IDLE;

            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

//--- source/serdes_rx_fifo.sv
// ========================================
// Synchronous FIFO of tagged packet lines
// ========================================
`include "serdes_consts.svh"

module serdes_rx_fifo (
   input  logic                        ser_rx_clk,
   input  logic                        rst_rxclk,
   input  logic                        write_i,
   input  serdes_pkt_pkg::rx_entry_t   wr_entry_i,
   output logic                        full_o,
   input  logic                        read_i,
   output serdes_pkt_pkg::rx_entry_t   rd_entry_o,
   output logic                        empty_o,
   output serdes_pkt_pkg::fifo_level_t level_o
);
   import serdes_pkt_pkg::*;

   localparam int depth = 1 << `RX_FIFO_AW;

   rx_entry_t               mem [depth];
   logic [`RX_FIFO_AW-1:0] wr_ptr;
   logic [`RX_FIFO_AW-1:0] rd_ptr;
   logic [`RX_FIFO_AW-1:0] count;
   logic                   do_write;
   logic                   do_read;

   assign do_write = write_i && !full_o;
   assign do_read  = read_i && !empty_o;

   assign full_o  = &count;   // One slot stays unused
   assign empty_o = (count == '0);
   assign level_o = fifo_level_t'(count);

   always_ff @(posedge ser_rx_clk)
   begin
      if (do_write)
         mem[wr_ptr] <= wr_entry_i;
      if (do_read)
         rd_entry_o <= mem[rd_ptr];   // Data valid the cycle after read
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_write && !do_read)
            count <= count + 1'b1;
         else if (do_read && !do_write)
            count <= count - 1'b1;
      end
   end

endmodule

//--- serdes_rx/serdes_rx_out.sv
// ========================================
// Consumer head register, flags and counts
// ========================================
`include "serdes_consts.svh"

module serdes_rx_out (
   input  logic                        ser_rx_clk,
   input  logic                        rst_rxclk,
   input  serdes_pkt_pkg::rx_entry_t   rd_entry_i,
   input  logic                        empty_i,
   input  serdes_pkt_pkg::fifo_level_t level_i,
   output logic                        fifo_read_o,
   output serdes_pkt_pkg::line_t       wr_dat_o,
   output serdes_pkt_pkg::rx_flags_t   wr_flags_o,
   input  logic                        wr_ready_i,
   output logic                        wr_ready_o,
   output serdes_pkt_pkg::fifo_level_t fifo_space_o,
   output serdes_pkt_pkg::fifo_level_t fifo_occupied_o
);
   import serdes_pkt_pkg::*;

   localparam fifo_level_t max_used = fifo_level_t'((1 << `RX_FIFO_AW) - 1);

   rx_entry_t head_q;
   logic      head_valid;
   logic      rd_pend;      // FIFO read in flight
   logic      take;

   assign take        = wr_ready_i && head_valid;
   assign fifo_read_o = !empty_i && !rd_pend && (!head_valid || take);

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         head_valid <= 1'b0;
         rd_pend    <= 1'b0;
      end
      else
      begin
         rd_pend <= fifo_read_o;
         if (rd_pend)
            head_valid <= 1'b1;
         else if (take)
            head_valid <= 1'b0;
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rd_pend)
         head_q <= rd_entry_i;
   end

   assign wr_ready_o = head_valid;
   assign wr_dat_o   = head_q.line;
   // Error raises both start and end
   assign wr_flags_o = {2'b00, head_q.eop | head_q.error, head_q.sop | head_q.error};

   // Words in flight and in the head count as occupied
   assign fifo_occupied_o = level_i + fifo_level_t'(head_valid) + fifo_level_t'(rd_pend);
   assign fifo_space_o    = (fifo_occupied_o >= max_used) ? '0 : max_used - fifo_occupied_o;

endmodule

//--- source/serdes_rx.sv
// ========================================
// SERDES receive top level
// ========================================
module serdes_rx (
   input  logic                        ser_rx_clk,
   input  logic                        rst_rxclk,
   input  serdes_sym_pkg::half_word_t  ser_r_i,
   input  logic                        ser_rklsb_i,
   input  logic                        ser_rkmsb_i,
   output serdes_pkt_pkg::line_t       wr_dat_o,
   output serdes_pkt_pkg::rx_flags_t   wr_flags_o,
   input  logic                        wr_ready_i,
   output logic                        wr_ready_o,
   output serdes_pkt_pkg::fifo_level_t fifo_space_o,
   output serdes_pkt_pkg::fifo_level_t fifo_occupied_o,
   output logic                        fifo_full_o,
   output logic                        fifo_empty_o,
   output logic                        xon_rcvd_o,
   output logic                        xoff_rcvd_o,
   output logic                        serdes_link_up_o
);
   import serdes_sym_pkg::*;
   import serdes_pkt_pkg::*;

   sym_pair_t   even_sym;
   sym_pair_t   odd_sym;
   logic        crc_clear;
   logic        crc_step;
   half_word_t  crc_data;
   half_word_t  crc_value;
   logic        fifo_write;
   logic        fifo_read;
   rx_entry_t   wr_entry;
   rx_entry_t   rd_entry;
   fifo_level_t level;

   serdes_rx_align u_align (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .rx_sym_i    ({ser_rkmsb_i, ser_rklsb_i, ser_r_i}),
      .even_sym_o  (even_sym),
      .odd_sym_o   (odd_sym),
      .xon_rcvd_o  (xon_rcvd_o),
      .xoff_rcvd_o (xoff_rcvd_o),
      .link_up_o   (serdes_link_up_o)
   );

   serdes_rx_framer u_framer (
      .ser_rx_clk   (ser_rx_clk),
      .rst_rxclk    (rst_rxclk),
      .even_sym_i   (even_sym),
      .odd_sym_i    (odd_sym),
      .full_i       (fifo_full_o),
      .crc_value_i  (crc_value),
      .crc_clear_o  (crc_clear),
      .crc_step_o   (crc_step),
      .crc_data_o   (crc_data),
      .fifo_write_o (fifo_write),
      .wr_entry_o   (wr_entry)
   );

   serdes_crc16 u_crc (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .clear_i    (crc_clear),
      .step_i     (crc_step),
      .data_i     (crc_data),
      .crc_o      (crc_value)
   );

   serdes_rx_fifo u_fifo (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .write_i    (fifo_write),
      .wr_entry_i (wr_entry),
      .full_o     (fifo_full_o),
      .read_i     (fifo_read),
      .rd_entry_o (rd_entry),
      .empty_o    (fifo_empty_o),
      .level_o    (level)
   );

   serdes_rx_out u_out (
      .ser_rx_clk      (ser_rx_clk),
      .rst_rxclk       (rst_rxclk),
      .rd_entry_i      (rd_entry),
      .empty_i         (fifo_empty_o),
      .level_i         (level),
      .fifo_read_o     (fifo_read),
      .wr_dat_o        (wr_dat_o),
      .wr_flags_o      (wr_flags_o),
      .wr_ready_i      (wr_ready_i),
      .wr_ready_o      (wr_ready_o),
      .fifo_space_o    (fifo_space_o),
      .fifo_occupied_o (fifo_occupied_o)
   );

endmodule

//--- verif/serdes_rx_tb_util.svh
// ========================================
// CRC model, LCG, symbol and packet senders for the testbench
// ========================================
`ifndef SERDES_RX_TB_UTIL_SVH
`define SERDES_RX_TB_UTIL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// Value in 0 .. n-1 from the stimulus stream
function automatic int rand_below(input int n);
   stim_seed = lcg_next(stim_seed);
   return int'(stim_seed[31:16]) % n;
endfunction

// Byte-wise CRC-16 CCITT model with the high byte of the half-word first
function automatic logic [15:0] crc_model(input logic [15:0] crc, input logic [15:0] hw);
   logic [15:0] c;
   logic [7:0]  b;
   c = crc;
   for (int n = 1; n >= 0; n--)
   begin
      b = hw[n*8 +: 8];
      c = c ^ {b, 8'h00};
      for (int i = 0; i < 8; i++)
         c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
   end
   return c;
endfunction

// Bytes go out low first and a pair is driven once both halves are known
task automatic put_byte(input logic [7:0] b, input logic k);
   if (!lo_pending)
   begin
      lo_byte_q  = b;
      lo_k_q     = k;
      lo_pending = 1'b1;
   end
   else
   begin
      @(posedge ser_rx_clk);
      ser_r_i     <= {b, lo_byte_q};
      ser_rklsb_i <= lo_k_q;
      ser_rkmsb_i <= k;
      lo_pending = 1'b0;
   end
endtask

task automatic send_pair(input logic k_hi, input logic [7:0] hi,
                         input logic k_lo, input logic [7:0] lo);
   put_byte(lo, k_lo);
   put_byte(hi, k_hi);
endtask

// Spacer data byte moves the stream to the wanted alignment
task automatic set_phase(input logic odd);
   if (lo_pending != odd)
      put_byte(8'h00, 1'b0);
endtask

task automatic send_idle(input int n);
   repeat (n)
      send_pair(1'b1, `K_COMMA, 1'b0, `D_56);
endtask

task automatic maybe_fill(input int pct);
   int pick;
   if (rand_below(100) < pct)
   begin
      pick = rand_below(3);
      if (pick == 0)
         send_pair(1'b1, `K_COMMA, 1'b0, `D_56);
      else if (pick == 1)
         send_pair(1'b1, `K_XON, 1'b1, `K_XON);
      else
         send_pair(1'b1, `K_XOFF, 1'b1, `K_XOFF);
   end
endtask

task automatic make_payload(input int n_half);
   payload_q.delete();
   repeat (n_half)
      payload_q.push_back(16'(rand_below(65536)));
endtask

task automatic push_line(input int idx, input logic sop, input logic eop);
   exp_line.push_back({payload_q[2*idx+1], payload_q[2*idx]});
   exp_flags.push_back({2'b00, eop, sop});
endtask

task automatic push_error();
   exp_line.push_back('0);
   exp_flags.push_back(4'b0011);
endtask

// Sends payload_q framed and queues the entries expected at each write point
task automatic send_packet(input int fill_pct, input logic bad_crc);
   logic [15:0] crc;
   logic [15:0] hw;
   int          n_lines;
   logic        failed;
   crc     = `CRC_INIT;
   n_lines = payload_q.size() / 2;
   failed  = 1'b0;
   send_pair(1'b1, `K_PKT_START, 1'b1, `K_PKT_START);
   for (int i = 0; i < payload_q.size(); i++)
   begin
      maybe_fill(fill_pct);
      hw = payload_q[i];
      send_pair(1'b0, hw[15:8], 1'b0, hw[7:0]);
      crc = crc_model(crc, hw);
      if ((i % 2 == 1) && !failed)
      begin
         if (exp_line.size() >= fifo_cap)   // Full at a write point
         begin
            push_error();
            failed = 1'b1;
         end
         else if (i > 1)
            push_line(i / 2 - 1, i == 3, 1'b0);
      end
   end
   maybe_fill(fill_pct);
   send_pair(1'b1, `K_PKT_END, 1'b1, `K_PKT_END);
   maybe_fill(fill_pct);
   if (bad_crc)
      crc = crc ^ 16'h0001;
   send_pair(1'b0, crc[15:8], 1'b0, crc[7:0]);
   if (!failed)
   begin
      if (bad_crc || (exp_line.size() >= fifo_cap))
         push_error();
      else
         push_line(n_lines - 1, n_lines == 1, 1'b1);
   end
endtask

`endif

//--- verif/serdes_rx_tb.sv
// ========================================
// Testbench top for the SERDES receive path
// ========================================
`include "serdes_consts.svh"

module serdes_rx_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int fifo_cap = 1 << `RX_FIFO_AW;   // FIFO entries plus output register
   localparam int max_syms = 6 * 200 + 66 * 60;
   localparam int timeout_cycles = 3 * max_syms + 4 * fifo_cap * 4;

   logic        ser_rx_clk;
   logic        rst_rxclk;
   logic [15:0] ser_r_i;
   logic        ser_rklsb_i;
   logic        ser_rkmsb_i;
   logic        wr_ready_i;
   logic [31:0] wr_dat_o;
   logic [3:0]  wr_flags_o;
   logic        wr_ready_o;
   logic [15:0] fifo_space_o;
   logic [15:0] fifo_occupied_o;
   logic        fifo_full_o;
   logic        fifo_empty_o;
   logic        xon_rcvd_o;
   logic        xoff_rcvd_o;
   logic        serdes_link_up_o;

   logic [31:0] stim_seed = 32'h33fedc49;
   logic [31:0] ready_seed = 32'h33fedc49;
   int          ready_mode = 0;   // 0 low, 1 random, 2 high
   logic [7:0]  lo_byte_q;
   logic        lo_k_q;
   logic        lo_pending = 1'b0;
   logic [15:0] payload_q [$];
   logic [31:0] exp_line [$];
   logic [3:0]  exp_flags [$];
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          test_err0;
   string       test_name;
   int          settle_cnt;
   logic        xon_in;
   logic        xoff_in;
   logic        good_in;

   `include "serdes_rx_tb_util.svh"

   serdes_rx DUT (
      .ser_rx_clk       (ser_rx_clk),
      .rst_rxclk        (rst_rxclk),
      .ser_r_i          (ser_r_i),
      .ser_rklsb_i      (ser_rklsb_i),
      .ser_rkmsb_i      (ser_rkmsb_i),
      .wr_dat_o         (wr_dat_o),
      .wr_flags_o       (wr_flags_o),
      .wr_ready_i       (wr_ready_i),
      .wr_ready_o       (wr_ready_o),
      .fifo_space_o     (fifo_space_o),
      .fifo_occupied_o  (fifo_occupied_o),
      .fifo_full_o      (fifo_full_o),
      .fifo_empty_o     (fifo_empty_o),
      .xon_rcvd_o       (xon_rcvd_o),
      .xoff_rcvd_o      (xoff_rcvd_o),
      .serdes_link_up_o (serdes_link_up_o)
   );

   initial
   begin
      ser_rx_clk = 1'b0;
      forever
         #20 ser_rx_clk = ~ser_rx_clk;
   end

   // Expected pulses and link state from the raw input pair
   assign xon_in  = (ser_rklsb_i && (ser_r_i[7:0] == `K_XON)) ||
                    (ser_rkmsb_i && (ser_r_i[15:8] == `K_XON));
   assign xoff_in = (ser_rklsb_i && (ser_r_i[7:0] == `K_XOFF)) ||
                    (ser_rkmsb_i && (ser_r_i[15:8] == `K_XOFF));
   assign good_in = !(ser_rklsb_i && ser_rkmsb_i &&
                      ((ser_r_i == {`K_ERROR, `K_ERROR}) || (ser_r_i == {`K_LOS, `K_LOS})));

   always @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         settle_cnt <= 0;
      else if (settle_cnt < 15)
         settle_cnt <= settle_cnt + 1;
   end

   xon_pulse: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk || settle_cnt < 8)
      xon_rcvd_o == $past(xon_in))
      else
      begin
         errors++;
         $display("Mismatch at %0t: xon_rcvd_o is %b", $time, xon_rcvd_o);
      end

   xoff_pulse: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk || settle_cnt < 8)
      xoff_rcvd_o == $past(xoff_in))
      else
      begin
         errors++;
         $display("Mismatch at %0t: xoff_rcvd_o is %b", $time, xoff_rcvd_o);
      end

   link_filter: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk || settle_cnt < 8)
      serdes_link_up_o == ($past(good_in, 3) && $past(good_in, 4) && $past(good_in, 5)))
      else
      begin
         errors++;
         $display("Mismatch at %0t: serdes_link_up_o is %b", $time, serdes_link_up_o);
      end

   // Space clamps at zero once the held word pushes the count past 511
   count_sum: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      (fifo_occupied_o <= fifo_cap - 1) ? (fifo_occupied_o + fifo_space_o == fifo_cap - 1)
                                        : (fifo_space_o == 0))
      else
      begin
         errors++;
         $display("Mismatch at %0t: occupied %0d space %0d", $time, fifo_occupied_o,
                  fifo_space_o);
      end

   full_space: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      fifo_full_o |-> (fifo_space_o == 0))
      else
      begin
         errors++;
         $display("Mismatch at %0t: full with space %0d", $time, fifo_space_o);
      end

   always @(posedge ser_rx_clk)
   begin
      ready_seed = lcg_next(ready_seed);
      if (ready_mode == 0)
         wr_ready_i <= 1'b0;
      else if (ready_mode == 1)
         wr_ready_i <= ready_seed[20];
      else
         wr_ready_i <= 1'b1;
   end

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp)
      else
      begin
         errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Word taken at the coming edge
   always @(negedge ser_rx_clk)
   begin
      if (!rst_rxclk && wr_ready_i && wr_ready_o)
      begin
         if (exp_line.size() == 0)
         begin
            errors++;
            $display("Unexpected word %h with flags %h at %0t", wr_dat_o, wr_flags_o, $time);
         end
         else
         begin
            check_equal(wr_dat_o, exp_line.pop_front(), "wr_dat_o");
            check_equal(32'(wr_flags_o), 32'(exp_flags.pop_front()), "wr_flags_o");
         end
      end
   end

   task automatic wait_drain(input int max_cycles);
      int n;
      n = 0;
      while ((exp_line.size() > 0) && (n < max_cycles))
      begin
         @(posedge ser_rx_clk);
         n++;
      end
      if (exp_line.size() > 0)
      begin
         errors++;
         $display("Drain timed out with %0d words still expected", exp_line.size());
         exp_line.delete();
         exp_flags.delete();
      end
      repeat (8)
         @(negedge ser_rx_clk);
   endtask

   task automatic wait_link(input logic level, input int max_cycles);
      int n;
      n = 0;
      @(negedge ser_rx_clk);
      while ((serdes_link_up_o !== level) && (n < max_cycles))
      begin
         @(negedge ser_rx_clk);
         n++;
      end
      if (serdes_link_up_o !== level)
      begin
         errors++;
         $display("Link level did not reach %b within %0d cycles", level, max_cycles);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == test_err0)
         $display("Test %0d %s: ok", tests_run, test_name);
      else
      begin
         tests_failed++;
         $display("Test %0d %s: fail, %0d errors", tests_run, test_name, errors - test_err0);
      end
   endtask

   initial
   begin
      rst_rxclk   = 1'b1;
      ser_r_i     = {`K_COMMA, `D_56};
      ser_rkmsb_i = 1'b1;
      ser_rklsb_i = 1'b0;
      wr_ready_i  = 1'b0;
      repeat (10)
         @(posedge ser_rx_clk);
      rst_rxclk <= 1'b0;
      @(negedge ser_rx_clk);
      check_equal(32'({wr_ready_o, xon_rcvd_o, xoff_rcvd_o, serdes_link_up_o}), 0,
                  "state after reset");
      send_idle(8);
      ready_mode = 1;

      begin_test("even packet");
      make_payload(2 * (4 + rand_below(12)));
      set_phase(1'b0);
      send_packet(0, 1'b0);
      send_idle(4);
      wait_drain(400);
      end_test();

      begin_test("odd packet");
      set_phase(1'b1);
      send_packet(0, 1'b0);   // Same payload one byte later
      send_idle(4);
      wait_drain(400);
      end_test();

      begin_test("bad crc");
      make_payload(10);
      set_phase(1'b0);
      send_packet(0, 1'b1);
      send_idle(4);
      wait_drain(400);
      end_test();

      begin_test("fill in packet");
      make_payload(24);
      set_phase(1'b0);
      send_packet(60, 1'b0);
      send_idle(4);
      make_payload(24);
      set_phase(1'b1);
      send_packet(60, 1'b0);
      send_idle(4);
      wait_drain(600);
      end_test();

      begin_test("back-pressure");
      ready_mode = 0;
      set_phase(1'b0);
      for (int p = 0; p < fifo_cap / 8; p++)
      begin
         make_payload(16);
         send_packet(20, 1'b0);
         send_idle(2);
      end
      repeat (8)
         @(negedge ser_rx_clk);
      check_equal(32'(fifo_full_o), 1, "fifo_full_o");
      check_equal(32'(fifo_occupied_o), exp_line.size(), "fifo_occupied_o");
      make_payload(16);
      send_packet(20, 1'b0);   // Overflows at its first line
      send_idle(4);
      check_equal(32'(fifo_full_o), 1, "fifo_full_o");
      ready_mode = 1;
      wait_drain(fifo_cap * 8 + 100);
      make_payload(8);
      send_packet(0, 1'b0);
      send_idle(4);
      wait_drain(400);
      end_test();

      begin_test("link monitor");
      set_phase(1'b0);
      send_idle(6);
      repeat (3)
         send_pair(1'b1, `K_LOS, 1'b1, `K_LOS);
      wait_link(1'b0, 6);
      send_idle(3);
      wait_link(1'b1, 8);
      repeat (3)
         send_pair(1'b1, `K_ERROR, 1'b1, `K_ERROR);
      wait_link(1'b0, 6);
      send_idle(3);
      wait_link(1'b1, 8);
      send_idle(6);
      if (!fifo_empty_o || wr_ready_o)
      begin
         errors++;
         $display("A word was written while no packet was open");
      end
      end_test();

      $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Bound from the worst-case symbol count and the drain time
   initial
   begin
      repeat (timeout_cycles)
         @(posedge ser_rx_clk);
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- files.f
+incdir+common
+incdir+verif
common/serdes_sym_pkg.sv
common/serdes_pkt_pkg.sv
source/serdes_crc16.sv
serdes_rx/serdes_rx_align.sv
serdes_rx/serdes_rx_framer.sv
source/serdes_rx_fifo.sv
serdes_rx/serdes_rx_out.sv
source/serdes_rx.sv
verif/serdes_rx_tb.sv
